// ==== run.sh ====
#!/bin/sh
# Build and run the enc_bus_bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_enc_bus_bridge -f tb.f --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

// ==== tb.f ====
verilog/enc_bus_pkg.sv
verilog/enc_addr_track.sv
verilog/enc_strobe_timer.sv
verilog/enc_bus_fsm.sv
verilog/enc_pin_drive.sv
verilog/enc_read_capture.sv
verilog/enc_bus_bridge.sv
verification/tb_enc_bus_bridge.sv

// ==== verification/tb_enc_bus_bridge.sv ====
`timescale 1ns/1ps

module tb_enc_bus_bridge;

   localparam int RESET_CYCLES    = 10;
   localparam int ACCESS_TIMEOUT  = 80;   // The SRAM burst read is the longest at about 50.
   localparam int NUM_ACCESSES    = 8;
   localparam int IRQ_CYCLES      = 10;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ACCESSES * (ACCESS_TIMEOUT + 3) +
                                    IRQ_CYCLES + 100;

   logic                   clk;
   logic                   rstn;
   enc_bus_pkg::host_req_t req;
   enc_bus_pkg::host_rsp_t rsp;
   enc_bus_pkg::enc_pins_t pins;
   logic [7:0]             ad_i;
   logic                   irq_n;
   logic                   interrupt;

   // Chip model state.
   logic [8:0] lat_addr = '0;     // Last latched SFR address.
   int         n = 0;             // EN pulses since the last latch.
   int         al_count = 0;
   int         oe_errs = 0;       // Drive enable wrong for the bus phase.
   int         hi_cnt = 0;
   int         lo_cnt = 0;
   int         gap_cnt = 0;
   logic       en_prev = 1'b0;
   logic       rnw_prev = 1'b0;
   logic [7:0] ad_prev = '0;
   logic [7:0] wr_bytes[$];       // Bytes seen on write pulses.
   int         hi_widths[$];
   int         lo_gaps[$];        // Low gap before each pulse.

   // Expected state of the address cache.
   logic        exp_cache_valid = 1'b0;
   logic [8:0]  exp_cache = '0;
   int          exp_n = 0;
   logic [31:0] rng_state = 32'h4fe6_c824;

   enc_bus_bridge UUT (.clk, .rstn, .req, .rsp, .pins, .ad_i, .irq_n, .interrupt);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;                 // 100 MHz.
   end

   function automatic logic [7:0] model_byte(input logic [8:0] addr, input int cnt);
      return 8'(addr[7:0] * 8'd3 + 8'(cnt));  // Read byte rule of the chip model.
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // 32-bit LCG.
      return rng_state;
   endfunction

   function automatic int start_n(input logic [8:0] sfr);
      return (exp_cache_valid && (exp_cache == sfr)) ? exp_n : 0;
   endfunction

   //************************************************************
   // Chip bus model sampled on the falling edge.
   //************************************************************
   assign ad_i = (pins.en && pins.rnw_ad8) ? model_byte(lat_addr, n) : 8'h00;

   always @(negedge clk)
   begin
      if (pins.al)
      begin
         lat_addr = {pins.rnw_ad8, pins.ad_o};   // AD8 plus AD7..AD0.
         al_count++;
         n = 0;
         if (!pins.ad_oe)
            oe_errs++;                          // Address must be driven.
      end
      if (pins.en)
      begin
         if (pins.ad_oe == pins.rnw_ad8)
            oe_errs++;                          // Writes drive the bus and reads release it.
         if (!en_prev)
         begin
            gap_cnt = lo_cnt;                   // Rising edge ends the low gap.
            hi_cnt  = 0;
         end
         hi_cnt++;
      end
      else
      begin
         if (en_prev)                           // Falling edge.
         begin
            if (!rnw_prev)
               wr_bytes.push_back(ad_prev);
            hi_widths.push_back(hi_cnt);
            lo_gaps.push_back(gap_cnt);
            n++;
            lo_cnt = 0;
         end
         lo_cnt++;
      end
      en_prev  = pins.en;
      rnw_prev = pins.rnw_ad8;
      ad_prev  = pins.ad_o;
   end

   //************************************************************
   // Checking and host access.
   //************************************************************
   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("error: %s expected %0h actual %0h", name, expected, actual);
         abort_run();
      end
   endtask

   // Full request and acknowledge cycle with the address and pulse count checks.
   task automatic host_access(input string name, input logic rnw, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
      logic [8:0]             sfr;
      logic                   expect_al;
      int                     first;
      int                     pulses;
      int                     wait_cnt;
      logic                   acked;
      logic                   got_rd;
      logic                   got_wr;
      enc_bus_pkg::host_rsp_t rsp_after;
      sfr       = addr[10:2];
      expect_al = !exp_cache_valid || (exp_cache != sfr);
      first     = start_n(sfr);
      pulses    = addr[enc_bus_pkg::BURST_BIT] ? 4 : 1;
      acked     = 1'b0;
      got_rd    = 1'b0;
      got_wr    = 1'b0;
      wait_cnt  = 0;
      rdata     = '0;
      @(posedge clk);
      wr_bytes.delete();
      hi_widths.delete();
      lo_gaps.delete();
      al_count = 0;
      oe_errs  = 0;
      req <= '{sel: 1'b1, rnw: rnw, addr: addr, wdata: wdata};
      while (!acked && (wait_cnt < ACCESS_TIMEOUT))
      begin
         @(negedge clk);
         if (rsp.wr_ack || rsp.rd_ack)
         begin
            acked  = 1'b1;
            got_rd = rsp.rd_ack;
            got_wr = rsp.wr_ack;
            rdata  = rsp.rdata;
         end
         wait_cnt++;
      end
      if (!acked)
      begin
         $display("%s: the bridge gave no acknowledge within %0d cycles", name, ACCESS_TIMEOUT);
         abort_run();
      end
      else
      begin
         @(posedge clk);
         req.sel <= 1'b0;                       // Dropped on the ack edge.
         @(negedge clk);
         rsp_after = rsp;
         @(posedge clk);                        // Model has logged the last fall.
         check({name, " rd_ack"}, 32'(rnw), 32'(got_rd));
         check({name, " wr_ack"}, 32'(!rnw), 32'(got_wr));
         check({name, " ack length"}, 32'd0, 32'(rsp_after.rd_ack || rsp_after.wr_ack));
         if (rnw)
            check({name, " rdata after ack"}, 32'd0, rsp_after.rdata);
         check({name, " al pulses"}, 32'(expect_al), al_count);
         check({name, " ad_oe errors"}, 32'd0, oe_errs);
         if (expect_al)
            check({name, " latched address"}, 32'(sfr), 32'(lat_addr));
         check({name, " en pulses"}, pulses, hi_widths.size());
         exp_cache_valid = 1'b1;
         exp_cache       = sfr;
         exp_n           = first + pulses;
      end
   endtask

   task automatic check_pulses(input string name, input int exp_hi, input int exp_gap);
      foreach (hi_widths[i])
      begin
         check($sformatf("%s high %0d", name, i), exp_hi, hi_widths[i]);
         if (i > 0)                             // First gap runs from idle.
            check($sformatf("%s gap %0d", name, i), exp_gap, lo_gaps[i]);
      end
   endtask

   task automatic check_write_bytes(input string name, input logic [31:0] wdata);
      check({name, " write bytes"}, hi_widths.size(), wr_bytes.size());
      foreach (wr_bytes[i])
         check($sformatf("%s byte %0d", name, i), 32'(wdata[i*8 +: 8]), 32'(wr_bytes[i]));
   endtask

   //************************************************************
   // Directed tests.
   //************************************************************
   task automatic test_reset();
      @(negedge clk);
      check("reset en", 32'd0, 32'(pins.en));
      check("reset al", 32'd0, 32'(pins.al));
      check("reset ad_oe", 32'd0, 32'(pins.ad_oe));
      check("reset rd_ack", 32'd0, 32'(rsp.rd_ack));
      check("reset wr_ack", 32'd0, 32'(rsp.wr_ack));
      check("reset interrupt", 32'd0, 32'(interrupt));
      check("reset rdata", 32'd0, rsp.rdata);
   endtask

   task automatic test_single_writes();
      logic [31:0] wdata;
      logic [31:0] rdata;
      wdata = next_random();
      host_access("write new", 1'b0, 12'h048, wdata, rdata);     // SFR 0x012.
      check_write_bytes("write new", wdata);
      wdata = next_random();
      host_access("write same", 1'b0, 12'h048, wdata, rdata);    // Cache hit without AL.
      check_write_bytes("write same", wdata);
      wdata = next_random();
      host_access("write other", 1'b0, 12'h694, wdata, rdata);   // SFR 0x1a5 with AD8 set.
      check_write_bytes("write other", wdata);
   endtask

   task automatic test_burst_write();
      logic [31:0] wdata;
      logic [31:0] rdata;
      wdata = next_random();
      host_access("burst write", 1'b0, 12'h8c0, wdata, rdata);
      check_write_bytes("burst write", wdata);
      check_pulses("burst write", 2, 2);
   endtask

   task automatic test_reads();
      logic [31:0] rdata;
      int          base;
      base = start_n(9'h044);
      host_access("burst read", 1'b1, 12'h910, '0, rdata);
      check("burst read data", {model_byte(9'h044, base + 3), model_byte(9'h044, base + 2),
            model_byte(9'h044, base + 1), model_byte(9'h044, base)}, rdata);
      check_pulses("burst read", 2, 1);
      base = start_n(9'h044);                  // Same SFR so n keeps counting.
      host_access("single read", 1'b1, 12'h110, '0, rdata);
      check("single read data", {24'h0, model_byte(9'h044, base)}, rdata);
   endtask

   task automatic test_sram_timing();
      logic [31:0] rdata;
      logic [31:0] wdata;
      int          base;
      base = start_n(enc_bus_pkg::ERXDATA);
      host_access("erxdata read", 1'b1, 12'ha08, '0, rdata);
      check("erxdata read data", {model_byte(9'h082, base + 3), model_byte(9'h082, base + 2),
            model_byte(9'h082, base + 1), model_byte(9'h082, base)}, rdata);
      check_pulses("erxdata read", 8, 4);
      wdata = next_random();
      host_access("egpdata write", 1'b0, 12'ha00, wdata, rdata);
      check_write_bytes("egpdata write", wdata);
      check_pulses("egpdata write", 2, 5);
   endtask

   task automatic test_interrupt();
      @(posedge clk);
      irq_n <= 1'b0;
      @(negedge clk);
      check("irq assert edge 0", 32'd0, 32'(interrupt));
      @(negedge clk);
      check("irq assert edge 1", 32'd0, 32'(interrupt));
      @(negedge clk);
      check("irq assert edge 2", 32'd1, 32'(interrupt));
      @(posedge clk);
      irq_n <= 1'b1;
      @(negedge clk);
      check("irq release edge 0", 32'd1, 32'(interrupt));
      @(negedge clk);
      check("irq release edge 1", 32'd1, 32'(interrupt));
      @(negedge clk);
      check("irq release edge 2", 32'd0, 32'(interrupt));
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   initial
   begin
      rstn  <= 1'b0;
      req   <= '0;
      irq_n <= 1'b1;                          // No interrupt request.
      repeat (RESET_CYCLES) @(posedge clk);
      rstn <= 1'b1;
      test_reset();
      test_single_writes();
      test_burst_write();
      test_reads();
      test_sram_timing();
      test_interrupt();
      $display("Test passed");
      $finish;
   end

endmodule

// ==== verilog/enc_addr_track.sv ====
`timescale 1ns/1ps

module enc_addr_track (
   input  logic                   clk,
   input  logic                   rstn,
   input  enc_bus_pkg::host_req_t  req,
   input  enc_bus_pkg::eth_state_e state,
   output logic                   addr_changed,
   output logic                   sram_access,
   output logic                   sram_read
);

   enc_bus_pkg::sfr_addr_t req_sfr;     // SFR address of the pending request.
   enc_bus_pkg::sfr_addr_t sfr_cache;   // Address last latched on the chip.
   logic                   cache_inv;   // Nothing latched yet.

   assign req_sfr = req.addr[10:2];     // Word address into the SFR space.

   //************************************************************
   // Address cache.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
         cache_inv <= 1'b1;
      else if (state == enc_bus_pkg::ETH_ADDR1)
         cache_inv <= 1'b0;             // Valid once the first latch goes out.
   end

   always_ff @(posedge clk)
   begin
      if (state == enc_bus_pkg::ETH_ADDR1)
         sfr_cache <= req_sfr;
   end

   assign addr_changed = cache_inv || (sfr_cache != req_sfr);

   // Access kind, captured when the request is accepted.
   always_ff @(posedge clk)
   begin
      if ((state == enc_bus_pkg::ETH_IDLE) && req.sel)
      begin
         sram_access <= (req_sfr == enc_bus_pkg::EGPDATA) ||
                        (req_sfr == enc_bus_pkg::ERXDATA) ||
                        (req_sfr == enc_bus_pkg::EUDADATA);
         sram_read   <= req.rnw;        // Only matters together with sram_access.
      end
   end

endmodule

// ==== verilog/enc_bus_bridge.sv ====
`timescale 1ns/1ps

module enc_bus_bridge (
   input  logic                         clk,
   input  logic                         rstn,
   input  enc_bus_pkg::host_req_t       req,
   output enc_bus_pkg::host_rsp_t       rsp,
   output enc_bus_pkg::enc_pins_t       pins,
   input  logic [enc_bus_pkg::AD_W-1:0] ad_i,
   input  logic                         irq_n,
   output logic                         interrupt
);

   enc_bus_pkg::eth_state_e         state;
   enc_bus_pkg::lane_t              lane;
   logic                            addr_changed, sram_access, sram_read;
   logic                            hi_done, lo_done;
   logic                            byte_strobe, burst_last, rd_done;
   logic [enc_bus_pkg::DATA_W-1:0]  rdata;
   logic [1:0]                      irq_sync;   // Two-flop synchroniser.

   //************************************************************
   // Datapath and control.
   //************************************************************
   enc_addr_track u_addr_track (.clk, .rstn, .req, .state,
                                .addr_changed, .sram_access, .sram_read);

   enc_strobe_timer u_strobe_timer (.clk, .state, .sram_access, .sram_read,
                                    .hi_done, .lo_done);

   enc_bus_fsm u_bus_fsm (.clk, .rstn, .req, .addr_changed, .hi_done, .lo_done,
                          .rd_done, .state, .lane, .byte_strobe, .burst_last);

   enc_pin_drive u_pin_drive (.clk, .rstn, .state, .req, .lane, .pins);

   enc_read_capture u_read_capture (.clk, .rstn, .ad_i, .byte_strobe, .burst_last,
                                    .rd_done, .rdata);

   // Host response.
   assign rsp = '{rd_ack: rd_done,
                  wr_ack: (state == enc_bus_pkg::ETH_WR_DONE),
                  rdata:  rdata};

   //************************************************************
   // Interrupt request, active low on the chip.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
         irq_sync <= 2'b11;                    // No request pending.
      else
         irq_sync <= {irq_sync[0], irq_n};
   end

   assign interrupt = ~irq_sync[1];

endmodule

// ==== verilog/enc_bus_fsm.sv ====
`timescale 1ns/1ps

module enc_bus_fsm (
   input  logic                    clk,
   input  logic                    rstn,
   input  enc_bus_pkg::host_req_t  req,
   input  logic                    addr_changed,
   input  logic                    hi_done,
   input  logic                    lo_done,
   input  logic                    rd_done,
   output enc_bus_pkg::eth_state_e state,
   output enc_bus_pkg::lane_t      lane,
   output logic                    byte_strobe,
   output logic                    burst_last
);

   enc_bus_pkg::eth_state_e next_state;
   enc_bus_pkg::lane_t      byte_cnt;   // Byte of the current burst.
   enc_bus_pkg::lane_t      byte_max;   // 3 for a burst, 0 for a single byte.
   logic                    start;      // Request accepted.
   logic                    byte_adv;   // End of a low phase.

   assign start    = (state == enc_bus_pkg::ETH_IDLE) && req.sel;
   assign byte_adv = ((state == enc_bus_pkg::ETH_WRITE3) ||
                      (state == enc_bus_pkg::ETH_READ3)) && lo_done;

   //************************************************************
   // Byte counter.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         byte_cnt <= '0;
         byte_max <= req.addr[enc_bus_pkg::BURST_BIT] ? 2'd3 : 2'd0;
      end
      else if (byte_adv)
         byte_cnt <= byte_cnt + 2'd1;
   end

   assign burst_last  = (byte_cnt == byte_max);
   assign lane        = byte_cnt;
   assign byte_strobe = (state == enc_bus_pkg::ETH_READ2) && hi_done;  // Last high cycle.

   //************************************************************
   // Transfer sequencer.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
         state <= enc_bus_pkg::ETH_IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state = state;                          // Hold by default.
      case (state)
         enc_bus_pkg::ETH_IDLE:
         begin
            if (req.sel)
            begin
               if (addr_changed)
                  next_state = enc_bus_pkg::ETH_ADDR1;   // Latch a new address first.
               else if (req.rnw)
                  next_state = enc_bus_pkg::ETH_READ1;
               else
                  next_state = enc_bus_pkg::ETH_WRITE1;
            end
         end
         enc_bus_pkg::ETH_ADDR1:
            next_state = enc_bus_pkg::ETH_ADDR2;         // AL pulse.
         enc_bus_pkg::ETH_ADDR2:                         // Address hold.
            next_state = req.rnw ? enc_bus_pkg::ETH_READ1 : enc_bus_pkg::ETH_WRITE1;

         // Write loop, one byte per pass.
         enc_bus_pkg::ETH_WRITE1:
            next_state = enc_bus_pkg::ETH_WRITE2;
         enc_bus_pkg::ETH_WRITE2:
         begin
            if (hi_done)
               next_state = burst_last ? enc_bus_pkg::ETH_WR_DONE : enc_bus_pkg::ETH_WRITE3;
         end
         enc_bus_pkg::ETH_WRITE3:
         begin
            if (lo_done)
               next_state = enc_bus_pkg::ETH_WRITE1;
         end

         // Read loop, READ1 only before the first byte.
         enc_bus_pkg::ETH_READ1:
            next_state = enc_bus_pkg::ETH_READ2;
         enc_bus_pkg::ETH_READ2:
         begin
            if (hi_done)
               next_state = burst_last ? enc_bus_pkg::ETH_RD_WAIT : enc_bus_pkg::ETH_READ3;
         end
         enc_bus_pkg::ETH_READ3:
         begin
            if (lo_done)
               next_state = enc_bus_pkg::ETH_READ2;
         end

         enc_bus_pkg::ETH_WR_DONE:
            next_state = enc_bus_pkg::ETH_IDLE;          // Write ack cycle.
         enc_bus_pkg::ETH_RD_WAIT:
         begin
            if (rd_done)                                 // Last byte assembled.
               next_state = enc_bus_pkg::ETH_IDLE;
         end
         default:
            next_state = enc_bus_pkg::ETH_IDLE;
      endcase
   end

endmodule

// ==== verilog/enc_bus_pkg.sv ====
package enc_bus_pkg;

   //************************************************************
   // Clock and chip timing limits.
   //************************************************************
   localparam int CLK_PERIOD_PS        = 10000;  // 100 MHz system clock.
   localparam int T_EN_SRAM_RD_HIGH_PS = 75000;  // EN high, SRAM window read.
   localparam int T_EN_OTHER_HIGH_PS   = 20000;  // EN high, everything else.
   localparam int T_EN_SRAM_RW_LOW_PS  = 40000;  // EN low, SRAM window access.
   localparam int T_EN_OTHER_LOW_PS    = 10000;  // EN low, everything else.

   // Limits rounded up to whole clocks.
   localparam int EN_SRAM_RD_HIGH_CLK =
      (T_EN_SRAM_RD_HIGH_PS + CLK_PERIOD_PS - 1) / CLK_PERIOD_PS;
   localparam int EN_OTHER_HIGH_CLK =
      (T_EN_OTHER_HIGH_PS + CLK_PERIOD_PS - 1) / CLK_PERIOD_PS;
   localparam int EN_SRAM_LOW_CLK =
      (T_EN_SRAM_RW_LOW_PS + CLK_PERIOD_PS - 1) / CLK_PERIOD_PS;
   localparam int EN_OTHER_LOW_CLK =
      (T_EN_OTHER_LOW_PS + CLK_PERIOD_PS - 1) / CLK_PERIOD_PS;

   // Counters hold count-1, so the longest count sets the width.
   localparam int ENH_CNT_W = $clog2(EN_SRAM_RD_HIGH_CLK);
   localparam int ENL_CNT_W = $clog2(EN_SRAM_LOW_CLK);

   localparam int SFR_ADDR_W  = 9;
   localparam int HOST_ADDR_W = 12;
   localparam int DATA_W      = 32;
   localparam int AD_W        = 8;
   localparam int LANES       = 4;
   localparam int BURST_BIT   = 11;   // Host address bit for 4-byte bursts.

   typedef logic [SFR_ADDR_W-1:0]    sfr_addr_t;
   typedef logic [$clog2(LANES)-1:0] lane_t;

   // SRAM window registers, longer EN timing.
   localparam sfr_addr_t EGPDATA  = 9'h080;
   localparam sfr_addr_t ERXDATA  = 9'h082;
   localparam sfr_addr_t EUDADATA = 9'h084;

   //************************************************************
   // Sequencer states and bus structs.
   //************************************************************
   typedef enum logic [3:0] {
      ETH_IDLE, ETH_ADDR1, ETH_ADDR2,
      ETH_WRITE1, ETH_WRITE2, ETH_WRITE3,
      ETH_READ1, ETH_READ2, ETH_READ3,
      ETH_WR_DONE, ETH_RD_WAIT
   } eth_state_e;

   typedef struct packed {
      logic                   sel;    // Request valid.
      logic                   rnw;    // 1 = read.
      logic [HOST_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]      wdata;
   } host_req_t;

   typedef struct packed {
      logic              rd_ack;
      logic              wr_ack;
      logic [DATA_W-1:0] rdata;
   } host_rsp_t;

   typedef struct packed {
      logic            en;       // Read/write enable.
      logic            al;       // Address latch.
      logic            rnw_ad8;  // R/W select, AD8 in the address phase.
      logic [AD_W-1:0] ad_o;
      logic            ad_oe;    // 1 = bridge drives AD.
   } enc_pins_t;

endpackage

// ==== verilog/enc_pin_drive.sv ====
`timescale 1ns/1ps

module enc_pin_drive (
   input  logic                    clk,
   input  logic                    rstn,
   input  enc_bus_pkg::eth_state_e state,
   input  enc_bus_pkg::host_req_t  req,
   input  enc_bus_pkg::lane_t      lane,
   output enc_bus_pkg::enc_pins_t  pins
);

   logic                        en_q;
   logic                        al_q;
   logic                        rnw_ad8_q;
   logic [enc_bus_pkg::AD_W-1:0] ad_q;
   logic                        oe_q;
   logic                        addr_ph;     // Address phase.
   logic                        rd_ph;       // Read loop.

   assign addr_ph = (state == enc_bus_pkg::ETH_ADDR1) || (state == enc_bus_pkg::ETH_ADDR2);
   assign rd_ph   = (state == enc_bus_pkg::ETH_READ1) || (state == enc_bus_pkg::ETH_READ2) ||
                    (state == enc_bus_pkg::ETH_READ3);

   //************************************************************
   // Strobes and drive enable.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         en_q <= 1'b0;
         al_q <= 1'b0;
         oe_q <= 1'b0;
      end
      else
      begin
         en_q <= (state == enc_bus_pkg::ETH_WRITE2) || (state == enc_bus_pkg::ETH_READ2);
         al_q <= (state == enc_bus_pkg::ETH_ADDR1);
         // Bus is driven from the address phase until the write ack.
         oe_q <= addr_ph ||
                 (state == enc_bus_pkg::ETH_WRITE1) || (state == enc_bus_pkg::ETH_WRITE2) ||
                 (state == enc_bus_pkg::ETH_WRITE3) || (state == enc_bus_pkg::ETH_WR_DONE);
      end
   end

   // Address and data byte.
   always_ff @(posedge clk)
   begin
      if (addr_ph)
      begin
         rnw_ad8_q <= req.addr[10];       // AD8.
         ad_q      <= req.addr[9:2];      // AD7..AD0.
      end
      else
      begin
         rnw_ad8_q <= rd_ph;              // High through the whole read loop.
         ad_q      <= req.wdata[lane*enc_bus_pkg::AD_W +: enc_bus_pkg::AD_W];
      end
   end

   assign pins = '{en:      en_q,
                   al:      al_q,
                   rnw_ad8: rnw_ad8_q,
                   ad_o:    ad_q,
                   ad_oe:   oe_q};

endmodule

// ==== verilog/enc_read_capture.sv ====
`timescale 1ns/1ps

module enc_read_capture (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [enc_bus_pkg::AD_W-1:0]   ad_i,
   input  logic                           byte_strobe,
   input  logic                           burst_last,
   output logic                           rd_done,
   output logic [enc_bus_pkg::DATA_W-1:0] rdata
);

   logic [enc_bus_pkg::AD_W-1:0]   ad_q;       // Registered chip byte.
   logic [1:0]                     valid_shr;  // byte_strobe delay line.
   logic [2:0]                     done_shr;   // Last-byte delay line.
   logic                           rd_valid;
   logic [enc_bus_pkg::DATA_W-1:0] word_q;
   enc_bus_pkg::lane_t             wr_lane;    // Next lane to fill.

   always_ff @(posedge clk)
   begin
      ad_q <= ad_i;
   end

   //************************************************************
   // Strobe delay lines.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         valid_shr <= '0;
         done_shr  <= '0;
      end
      else
      begin
         valid_shr <= {valid_shr[0], byte_strobe};
         done_shr  <= {done_shr[1:0], byte_strobe && burst_last};
      end
   end

   assign rd_valid = valid_shr[1];   // ad_q holds the sampled byte now.
   assign rd_done  = done_shr[2];    // One cycle after the last lane write.

   // Word assembly, lanes 0 to 3 in order.
   always_ff @(posedge clk)
   begin
      if (!rstn || rd_done)
      begin
         word_q  <= '0;               // Zero again after the ack cycle.
         wr_lane <= '0;
      end
      else if (rd_valid)
      begin
         word_q[wr_lane*enc_bus_pkg::AD_W +: enc_bus_pkg::AD_W] <= ad_q;
         wr_lane <= wr_lane + 2'd1;
      end
   end

   assign rdata = word_q;

endmodule

// ==== verilog/enc_strobe_timer.sv ====
`timescale 1ns/1ps

module enc_strobe_timer (
   input  logic                   clk,
   input  enc_bus_pkg::eth_state_e state,
   input  logic                   sram_access,
   input  logic                   sram_read,
   output logic                   hi_done,
   output logic                   lo_done
);

   typedef logic [enc_bus_pkg::ENH_CNT_W-1:0] enh_cnt_t;
   typedef logic [enc_bus_pkg::ENL_CNT_W-1:0] enl_cnt_t;

   enh_cnt_t enh_cnt;   // EN high time remaining.
   enl_cnt_t enl_cnt;   // EN low time remaining.
   logic     x1x3;      // Before a high phase.
   logic     x2;        // EN high.
   logic     x3;        // EN low between bytes.

   assign x1x3 = (state == enc_bus_pkg::ETH_WRITE1) || (state == enc_bus_pkg::ETH_READ1) ||
                 (state == enc_bus_pkg::ETH_WRITE3) || (state == enc_bus_pkg::ETH_READ3);
   assign x2   = (state == enc_bus_pkg::ETH_WRITE2) || (state == enc_bus_pkg::ETH_READ2);
   assign x3   = (state == enc_bus_pkg::ETH_WRITE3) || (state == enc_bus_pkg::ETH_READ3);

   //************************************************************
   // EN high time counter.
   //************************************************************
   always_ff @(posedge clk)
   begin
      if (x1x3)
      begin
         if (sram_access && sram_read)            // SRAM window read is slowest.
            enh_cnt <= enh_cnt_t'(enc_bus_pkg::EN_SRAM_RD_HIGH_CLK - 1);
         else
            enh_cnt <= enh_cnt_t'(enc_bus_pkg::EN_OTHER_HIGH_CLK - 1);
      end
      else if (x2)
         enh_cnt <= enh_cnt - enh_cnt_t'(1);
   end

   // EN low time counter, reloaded every high cycle.
   always_ff @(posedge clk)
   begin
      if (x2)
      begin
         if (sram_access)
            enl_cnt <= enl_cnt_t'(enc_bus_pkg::EN_SRAM_LOW_CLK - 1);
         else
            enl_cnt <= enl_cnt_t'(enc_bus_pkg::EN_OTHER_LOW_CLK - 1);
      end
      else if (x3)
         enl_cnt <= enl_cnt - enl_cnt_t'(1);
   end

   assign hi_done = (enh_cnt == '0);  // Last high cycle.
   assign lo_done = (enl_cnt == '0);  // Last low cycle.

endmodule
